//--- sim/hex_load_tests.txt
# name  characters (\s space, \r CR, \n LF, \g pause below timeout, \w pause past timeout)
#       key  last_address  last_data  error  shown_number
echo_text           Hi!\n                              1111 00000000 00000000 0 210a
address_words       @100\s11223344\sAABBCCDD\s55\n     0111 00000108 00000055 0 2035
mixed_case          @aB0\r\nfEdC\r\n7\n                1110 00000ab4 00000007 0 0ab4
full_word           @0\sdeadbeef\n                     1011 00000000 deadbeef 0 dead
bad_char_resume     @20\s12\s3g4\s56\n78\s             1101 00000024 00000078 0 0078
bad_char_held       @40\s1\sz\s2\s                     1110 00000040 00000001 1 0040
nine_digits_held    @8\s5\s123456789\s6\s              1101 00000008 00000005 1 0005
nine_digits_resume  @8\s123456789\n9\s                 1101 00000008 00000009 0 0009
eight_digit_tokens  @1000FFF8\s12345678\s9ABCDEF0\n    1110 1000fffc 9abcdef0 0 fffc
timeout_held        @10\s7\w\s                         1101 00000000 00000000 1 0000
timeout_resume      @10\s7\w\n3\s                      1101 00000010 00000003 0 0003
slow_digits         @30\s1\g2\g3\s                     1101 00000030 00000123 0 0123
stray_at            12@\n                              0111 00000000 00000000 0 3132
separators_only     \s\r\n\s                           1111 00000000 00000000 0 0a20
no_address          5\s6\n                             1110 00000004 00000006 0 0004

//--- sources.f
+incdir+common
common/hex_load_pkg.sv
uart/uart_receiver.sv
uart/uart_transmitter.sv
verilog/hex_parser.sv
verilog/readout_select.sv
verilog/seven_segment_display.sv
verilog/hex_load_top.sv
sim/tb_hex_load.sv

//--- run_sim.sh
#!/bin/sh
# build and run the hex loader testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 --top-module tb_hex_load -f sources.f -o tb_hex_load

./obj_dir/tb_hex_load > sim.log 2>&1 || true
cat sim.log

if grep -q "Finished with no errors" sim.log; then
    exit 0
fi
exit 1

//--- sim/tb_hex_load.sv
`timescale 1ns/100ps

`include "hex_load_defs.svh"

module tb_hex_load;

    localparam clocks_per_bit = 8;
    localparam clock_period   = 40;
    localparam w_digit        = `HL_W_DIGIT;
    localparam short_pause    = 200;
    localparam long_pause     = 500;
    localparam short_code     = 256;
    localparam long_code      = 257;

    logic                 clk;
    logic                 rst;
    logic                 uart_rx;
    logic [3:0]           key;
    logic                 uart_tx;
    logic [3:0]           led;
    logic [7:0]           abcdefgh;
    logic [w_digit - 1:0] digit;

    logic [7:0]  echo_q [$];
    logic [7:0]  sent_q [$];
    int          stimulus_q [$];
    logic [31:0] rng;
    int          byte_pulses;

    hex_load_top
    #(
        .clocks_per_bit (clocks_per_bit),
        .timeout_cycles (400),
        .refresh_cycles (4)
    )
    DUT
    (
        .clk      (clk),
        .rst      (rst),
        .uart_rx  (uart_rx),
        .key      (key),
        .uart_tx  (uart_tx),
        .led      (led),
        .abcdefgh (abcdefgh),
        .digit    (digit)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #(clock_period / 2) clk = ~clk;
    end

    // ----------------------------------------
    // reporting and helpers
    // ----------------------------------------

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check(input string name, input string what,
                         input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("FAIL %s %s: expected %h, actual %h", name, what, expected, actual);
            stop_with_failure("a checked value did not match");
        end
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic idle(input int cycles);
        repeat (cycles) @(negedge clk);
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst = 1'b1;
        repeat (5) @(negedge clk);
        check("reset", "uart_tx", 32'd1, 32'(uart_tx));
        check("reset", "led", 32'hf, 32'(led));
        check("reset", "digit", 32'hff, 32'(digit));
        rst = 1'b0;
    endtask

    // one 8N1 frame, lsb first
    task automatic send_byte(input logic [7:0] c);
        logic [9:0] frame;
        frame = {1'b1, c, 1'b0};
        for (int i = 0; i < 10; i++)
        begin
            @(negedge clk);
            uart_rx = frame[0];
            frame   = frame >> 1;
            repeat (clocks_per_bit - 1) @(negedge clk);
        end
    endtask

    // echo decoder, samples near each bit centre
    initial
    begin
        logic [7:0] rx_byte;
        forever
        begin
            @(negedge clk);
            if (rst === 1'b0 && uart_tx === 1'b0)
            begin
                repeat (clocks_per_bit / 2) @(negedge clk);
                for (int i = 0; i < 8; i++)
                begin
                    repeat (clocks_per_bit) @(negedge clk);
                    rx_byte = {uart_tx, rx_byte[7:1]};
                end
                repeat (clocks_per_bit) @(negedge clk);
                if (uart_tx !== 1'b1)
                    stop_with_failure("echoed frame has a low stop bit");
                else
                    echo_q.push_back(rx_byte);
            end
        end
    end

    // received byte pulses as seen on led bit 3
    always @(negedge clk)
        if (rst === 1'b0 && led[3] === 1'b0)
            byte_pulses++;

    // ----------------------------------------
    // display readback
    // ----------------------------------------

    // segments {a,b,c,d,e,f,g}, bit 4 flags an unknown pattern
    function automatic logic [4:0] segments_to_nibble(input logic [6:0] seg);
        logic [4:0] n;
        case (seg)
        7'b1111110: n = 5'h00;
        7'b0110000: n = 5'h01;
        7'b1101101: n = 5'h02;
        7'b1111001: n = 5'h03;
        7'b0110011: n = 5'h04;
        7'b1011011: n = 5'h05;
        7'b1011111: n = 5'h06;
        7'b1110000: n = 5'h07;
        7'b1111111: n = 5'h08;
        7'b1111011: n = 5'h09;
        7'b1110111: n = 5'h0a;
        7'b0011111: n = 5'h0b;
        7'b1001110: n = 5'h0c;
        7'b0111101: n = 5'h0d;
        7'b1001111: n = 5'h0e;
        7'b1000111: n = 5'h0f;
        default:    n = 5'h10;
        endcase
        return n;
    endfunction

    task automatic read_display(input string name, output logic [31:0] value);
        logic [4:0]           nib;
        logic [w_digit - 1:0] want;
        int                   waited;
        value = '0;
        @(negedge clk);
        for (int i = 0; i < w_digit; i++)
        begin
            want   = ~(w_digit'(1) << i);
            waited = 0;
            while (digit !== want)
                if (waited == 100)
                    stop_with_failure($sformatf("digit %0d never enabled", i));
                else
                begin
                    @(negedge clk);
                    waited++;
                end
            check(name, "decimal point", 32'd0, 32'(abcdefgh[0]));
            nib = segments_to_nibble(abcdefgh[7:1]);
            if (nib[4])
                stop_with_failure($sformatf("unknown segment pattern %b", abcdefgh));
            else
                value = {nib[3:0], value[31:4]};
        end
    endtask

    // key table of the readout, keys active low
    function automatic logic [15:0] expected_for_key(input logic [3:0] k,
        input logic [31:0] bytes, input logic [31:0] address, input logic [31:0] data);
        case (k)
        4'b0111: return bytes[31:16];
        4'b1011: return data[31:16];
        4'b1101: return data[15:0];
        4'b1110: return address[15:0];
        default: return bytes[15:0];
        endcase
    endfunction

    task automatic check_display(input string name, input logic [3:0] k,
                                 input logic [15:0] expected);
        logic [31:0] shown;
        @(negedge clk);
        key = k;
        read_display(name, shown);
        check(name, $sformatf("display for key %b", k), {16'h0000, expected}, shown);
    endtask

    // escapes: \s space, \r CR, \n LF, \g short pause, \w long pause
    task automatic load_stimulus(input logic [8*96-1:0] raw);
        logic [7:0]      c;
        logic            escape;
        logic [8*96-1:0] rest;
        stimulus_q.delete();
        escape = 1'b0;
        rest   = raw;
        for (int i = 0; i < 96; i++)
        begin
            c    = rest[8*96-1 -: 8];
            rest = rest << 8;
            if (c != 8'h00)
            begin
                if (escape)
                begin
                    case (c)
                    "n":     stimulus_q.push_back(10);
                    "r":     stimulus_q.push_back(13);
                    "s":     stimulus_q.push_back(32);
                    "g":     stimulus_q.push_back(short_code);
                    "w":     stimulus_q.push_back(long_code);
                    default: stop_with_failure("unknown escape code in the test file");
                    endcase
                    escape = 1'b0;
                end
                else if (c == 8'h5c)
                    escape = 1'b1;
                else
                    stimulus_q.push_back(int'(c));
            end
        end
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------

    initial
    begin
        int               fd;
        int               fields;
        int               records;
        int               waited;
        int               pulses_before;
        logic [8*256-1:0] line;
        logic [8*32-1:0]  first;
        logic [8*32-1:0]  name_raw;
        logic [8*96-1:0]  chars;
        logic [3:0]       exp_key;
        logic [31:0]      exp_addr;
        logic [31:0]      exp_data;
        logic [31:0]      exp_error;
        logic [15:0]      exp_shown;
        logic [31:0]      recent;
        logic [7:0]       c;
        string            name;

        uart_rx = 1'b1;
        key     = 4'b1111;
        rst     = 1'b1;
        rng     = 32'd13644;
        records = 0;

        fd = $fopen("sim/hex_load_tests.txt", "r");
        if (fd == 0)
            stop_with_failure("cannot open sim/hex_load_tests.txt");

        while ($fgets(line, fd) != 0)
        begin
            fields = $sscanf(line, "%s", first);
            if (fields == 1 && !(first[7:0] == "#" && first[8*32-1:8] == '0))
            begin
                fields = $sscanf(line, "%s %s %b %h %h %h %h", name_raw, chars, exp_key,
                                 exp_addr, exp_data, exp_error, exp_shown);
                if (fields != 7)
                    stop_with_failure("malformed record in the test file");
                name = $sformatf("%0s", name_raw);
                records++;

                apply_reset();
                echo_q.delete();
                sent_q.delete();
                recent        = '0;
                pulses_before = byte_pulses;
                load_stimulus(chars);

                foreach (stimulus_q[i])
                    if (stimulus_q[i] == long_code)
                        idle(long_pause);
                    else if (stimulus_q[i] == short_code)
                        idle(short_pause);
                    else
                    begin
                        c = 8'(stimulus_q[i]);
                        send_byte(c);
                        sent_q.push_back(c);
                        recent = {recent[23:0], c};
                        rng    = xorshift(rng);
                        idle(8 + int'(rng[5:0]));
                    end

                waited = 0;
                while (echo_q.size() < sent_q.size())
                    if (waited == 2000)
                        stop_with_failure($sformatf("%s: echo did not arrive", name));
                    else
                    begin
                        @(negedge clk);
                        waited++;
                    end

                check(name, "echo count", 32'(sent_q.size()), 32'(echo_q.size()));
                foreach (sent_q[i])
                    check(name, $sformatf("echo of character %0d", i),
                          32'(sent_q[i]), 32'(echo_q[i]));

                check(name, "byte pulses", 32'(sent_q.size()),
                      32'(byte_pulses - pulses_before));

                // every string ends on a separator, so no token stays open
                check(name, "status leds", {28'h0000000, 3'b111, ~exp_error[0]},
                      32'(led));

                // last word through the readout keys
                check_display(name, 4'b1110, exp_addr[15:0]);
                check_display(name, 4'b1101, exp_data[15:0]);
                check_display(name, 4'b1011, exp_data[31:16]);
                check_display(name, exp_key, exp_shown);

                for (int r = 0; r < 2; r++)
                begin
                    rng = xorshift(rng);
                    check_display(name, rng[3:0],
                                  expected_for_key(rng[3:0], recent, exp_addr, exp_data));
                end
            end
        end
        $fclose(fd);

        if (records == 0)
            stop_with_failure("no test records in the test file");
        else
        begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

//--- verilog/hex_load_top.sv
`timescale 1ns/100ps

`include "hex_load_defs.svh"

module hex_load_top
#(
    parameter clocks_per_bit = `HL_CLOCKS_PER_BIT,
              timeout_cycles = `HL_TIMEOUT_CYCLES,
              refresh_cycles = `HL_REFRESH_CYCLES
)
(
    input                            clk,
    input                            rst,
    input                            uart_rx,
    input        [3:0]               key,
    output logic                     uart_tx,
    output logic [3:0]               led,
    output logic [7:0]               abcdefgh,
    output logic [`HL_W_DIGIT - 1:0] digit
);

    logic                       byte_valid;
    hex_load_pkg::byte_t        byte_data;
    logic                       word_valid;
    hex_load_pkg::parsed_word_t word;
    logic                       busy;
    logic                       error;
    logic [31:0]                number;

    // ----------------------------------------
    // serial in and echo
    // ----------------------------------------

    uart_receiver #(.clocks_per_bit(clocks_per_bit)) receiver
    (
        .clk        (clk),
        .rst        (rst),
        .rx         (uart_rx),
        .byte_valid (byte_valid),
        .byte_data  (byte_data)
    );

    // at equal baud rates the transmitter is always free here
    uart_transmitter #(.clocks_per_bit(clocks_per_bit)) transmitter
    (
        .clk        (clk),
        .rst        (rst),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .byte_ready (),
        .tx         (uart_tx)
    );

    // ----------------------------------------
    // parser and readout
    // ----------------------------------------

    hex_parser #(.timeout_cycles(timeout_cycles)) parser
    (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (byte_valid),
        .in_char    (byte_data),
        .word_valid (word_valid),
        .word       (word),
        .busy       (busy),
        .error      (error)
    );

    readout_select readout
    (
        .clk        (clk),
        .rst        (rst),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .word_valid (word_valid),
        .word       (word),
        .key        (key),
        .number     (number)
    );

    seven_segment_display
    #(
        .w_digit        (`HL_W_DIGIT),
        .refresh_cycles (refresh_cycles)
    )
    display
    (
        .clk      (clk),
        .rst      (rst),
        .number   (number),
        .abcdefgh (abcdefgh),
        .digit    (digit)
    );

    // leds light on low
    assign led = ~{byte_valid, word_valid, busy, error};

endmodule

//--- verilog/seven_segment_display.sv
`timescale 1ns/100ps

`include "hex_load_defs.svh"

module seven_segment_display
#(
    parameter w_digit        = `HL_W_DIGIT,
              refresh_cycles = `HL_REFRESH_CYCLES
)
(
    input                            clk,
    input                            rst,
    input        [w_digit * 4 - 1:0] number,
    output logic [7:0]               abcdefgh,
    output logic [w_digit - 1:0]     digit
);

    localparam w_refresh = $clog2(refresh_cycles + 1);
    localparam w_index   = $clog2(w_digit);

    logic [w_refresh - 1:0]  refresh;
    logic [w_index - 1:0]    index;
    hex_load_pkg::nibble_t   nibble;
    logic [7:0]              segments;

    // ----------------------------------------
    // digit scan
    // ----------------------------------------

    always_ff @(posedge clk or posedge rst)
        if (rst)
        begin
            refresh <= '0;
            index   <= '0;
        end
        else if (refresh == w_refresh'(refresh_cycles - 1))
        begin
            refresh <= '0;
            index   <= (index == w_index'(w_digit - 1)) ? '0 : index + 1'b1;
        end
        else
            refresh <= refresh + 1'b1;

    assign nibble = number[index * 4 +: 4];

    // segments a..g in bits 7..1, dot stays off
    always_comb
        case (nibble)
        4'h0: segments = 8'b1111_1100;
        4'h1: segments = 8'b0110_0000;
        4'h2: segments = 8'b1101_1010;
        4'h3: segments = 8'b1111_0010;
        4'h4: segments = 8'b0110_0110;
        4'h5: segments = 8'b1011_0110;
        4'h6: segments = 8'b1011_1110;
        4'h7: segments = 8'b1110_0000;
        4'h8: segments = 8'b1111_1110;
        4'h9: segments = 8'b1111_0110;
        4'ha: segments = 8'b1110_1110;
        4'hb: segments = 8'b0011_1110;
        4'hc: segments = 8'b1001_1100;
        4'hd: segments = 8'b0111_1010;
        4'he: segments = 8'b1001_1110;
        default: segments = 8'b1000_1110;
        endcase

    // index 0 is the rightmost digit, enables active low
    always_ff @(posedge clk or posedge rst)
        if (rst)
        begin
            abcdefgh <= '0;
            digit    <= '1;
        end
        else
        begin
            abcdefgh <= segments;
            digit    <= ~(w_digit'(1) << index);
        end

endmodule

//--- verilog/readout_select.sv
`timescale 1ns/100ps

module readout_select
(
    input                               clk,
    input                               rst,
    input                               byte_valid,
    input  hex_load_pkg::byte_t         byte_data,
    input                               word_valid,
    input  hex_load_pkg::parsed_word_t  word,
    input        [3:0]                  key,
    output logic [31:0]                 number
);

    logic [31:0]                last_bytes;
    hex_load_pkg::parsed_word_t last_word;
    logic [15:0]                shown;

    // newest byte in the low eight bits
    always_ff @(posedge clk or posedge rst)
        if (rst)
            last_bytes <= '0;
        else if (byte_valid)
            last_bytes <= {last_bytes[23:0], byte_data};

    always_ff @(posedge clk or posedge rst)
        if (rst)
            last_word <= '0;
        else if (word_valid)
            last_word <= word;

    // keys are active low
    always_comb
        case (key)
        4'b0111: shown = last_bytes[31:16];
        4'b1011: shown = last_word.data[31:16];
        4'b1101: shown = last_word.data[15:0];
        4'b1110: shown = last_word.address[15:0];
        default: shown = last_bytes[15:0];
        endcase

    assign number = {16'h0000, shown};

endmodule

//--- verilog/hex_parser.sv
`timescale 1ns/100ps

`include "hex_load_defs.svh"

module hex_parser
#(
    parameter timeout_cycles = `HL_TIMEOUT_CYCLES
)
(
    input                                clk,
    input                                rst,
    input                                in_valid,
    input  hex_load_pkg::byte_t          in_char,
    output logic                         word_valid,
    output hex_load_pkg::parsed_word_t   word,
    output logic                         busy,
    output logic                         error
);

    localparam w_timer = $clog2(timeout_cycles + 1);

    hex_load_pkg::parser_state_t state;
    hex_load_pkg::word_t         acc;
    hex_load_pkg::addr_t         address;
    hex_load_pkg::nibble_t       nibble;
    logic [3:0]                  n_digits;
    logic [w_timer - 1:0]        timer;

    logic is_digit;
    logic is_at;
    logic is_sep;
    logic is_lf;
    logic token_end;
    logic emit;
    logic fail;
    logic timeout_hit;

    // ----------------------------------------
    // character classifier
    // ----------------------------------------

    always_comb
    begin
        is_digit = 1'b0;
        nibble   = in_char[3:0];

        if (in_char >= "0" && in_char <= "9")
            is_digit = 1'b1;
        else if ((in_char >= "a" && in_char <= "f")
              || (in_char >= "A" && in_char <= "F"))
        begin
            // low nibble of 'a' and 'A' is 1
            is_digit = 1'b1;
            nibble   = in_char[3:0] + 4'd9;
        end
    end

    assign is_at  = (in_char == "@");
    assign is_lf  = (in_char == 8'h0a);
    assign is_sep = is_lf || in_char == 8'h0d || in_char == " ";

    assign busy  = (n_digits != 4'd0);
    assign error = (state == hex_load_pkg::ps_error);

    // separator that closes a token with digits
    assign token_end = in_valid && !error && is_sep && busy;
    assign emit      = token_end && state == hex_load_pkg::ps_data;

    // ninth digit, stray '@' or unknown character
    assign fail = in_valid && !error
                  && ((is_digit && n_digits == 4'd8)
                   || (is_at && busy)
                   || (!is_digit && !is_at && !is_sep));

    assign timeout_hit = !in_valid && busy && timer == w_timer'(timeout_cycles - 1);

    // ----------------------------------------
    // token state machine
    // ----------------------------------------

    always_ff @(posedge clk or posedge rst)
        if (rst)
        begin
            state      <= hex_load_pkg::ps_idle;
            acc        <= '0;
            n_digits   <= '0;
            address    <= '0;
            word_valid <= 1'b0;
        end
        else
        begin
            word_valid <= emit;

            if (fail || timeout_hit)
            begin
                state    <= hex_load_pkg::ps_error;
                acc      <= '0;
                n_digits <= '0;
            end
            else if (in_valid)
            begin
                if (error)
                begin
                    if (is_lf)
                        state <= hex_load_pkg::ps_idle;
                end
                else if (is_digit)
                begin
                    acc      <= {acc[27:0], nibble};
                    n_digits <= n_digits + 1'b1;
                    if (state == hex_load_pkg::ps_idle)
                        state <= hex_load_pkg::ps_data;
                end
                else if (is_at)
                    state <= hex_load_pkg::ps_address;
                else if (token_end)
                begin
                    if (state == hex_load_pkg::ps_address)
                        address <= acc;
                    else
                        address <= address + 32'd4;
                    state    <= hex_load_pkg::ps_idle;
                    acc      <= '0;
                    n_digits <= '0;
                end
            end
        end

    // silence counter, restarts on every byte
    always_ff @(posedge clk or posedge rst)
        if (rst)
            timer <= '0;
        else if (in_valid || !busy)
            timer <= '0;
        else
            timer <= timer + 1'b1;

    always_ff @(posedge clk)
        if (emit)
        begin
            word.address <= address;
            word.data    <= acc;
        end

endmodule

//--- uart/uart_transmitter.sv
`timescale 1ns/100ps

`include "hex_load_defs.svh"

module uart_transmitter
#(
    parameter clocks_per_bit = `HL_CLOCKS_PER_BIT
)
(
    input                        clk,
    input                        rst,
    input                        byte_valid,
    input  hex_load_pkg::byte_t  byte_data,
    output logic                 byte_ready,
    output logic                 tx
);

    localparam w_cnt = $clog2(clocks_per_bit + 1);

    logic                active;
    logic [9:0]          frame;
    logic [3:0]          bit_cnt;
    logic [w_cnt - 1:0]  cnt;
    logic                accept;
    logic                bit_end;

    assign accept  = byte_valid && byte_ready;
    assign bit_end = (cnt == w_cnt'(clocks_per_bit - 1));

    // ----------------------------------------
    // bit timing
    // ----------------------------------------

    always_ff @(posedge clk or posedge rst)
        if (rst)
        begin
            active  <= 1'b0;
            bit_cnt <= '0;
            cnt     <= '0;
        end
        else if (accept)
        begin
            active  <= 1'b1;
            bit_cnt <= '0;
            cnt     <= '0;
        end
        else if (active)
        begin
            if (bit_end)
            begin
                cnt     <= '0;
                bit_cnt <= bit_cnt + 1'b1;
                // done after the stop bit
                if (bit_cnt == 4'd9)
                    active <= 1'b0;
            end
            else
            begin
                cnt <= cnt + 1'b1;
            end
        end

    // stop, data, start; shifted out from bit 0
    always_ff @(posedge clk)
        if (accept)
            frame <= {1'b1, byte_data, 1'b0};
        else if (active && bit_end)
            frame <= {1'b1, frame[9:1]};

    assign byte_ready = !active;
    assign tx         = active ? frame[0] : 1'b1;

endmodule

//--- uart/uart_receiver.sv
`timescale 1ns/100ps

`include "hex_load_defs.svh"

module uart_receiver
#(
    parameter clocks_per_bit = `HL_CLOCKS_PER_BIT
)
(
    input                         clk,
    input                         rst,
    input                         rx,
    output logic                  byte_valid,
    output hex_load_pkg::byte_t   byte_data
);

    localparam w_cnt = $clog2(clocks_per_bit + 1);

    typedef enum logic [1:0]
    {
        rx_idle,
        rx_start,
        rx_data,
        rx_stop
    } rx_state_t;

    rx_state_t           state;
    logic [w_cnt - 1:0]  cnt;
    logic [2:0]          bit_idx;
    logic [1:0]          rx_sync;
    logic                rx_prev;
    hex_load_pkg::byte_t shift;

    // two-flop synchronizer, line idles high
    always_ff @(posedge clk or posedge rst)
        if (rst)
        begin
            rx_sync <= 2'b11;
            rx_prev <= 1'b1;
        end
        else
        begin
            rx_sync <= {rx_sync[0], rx};
            rx_prev <= rx_sync[1];
        end

    // ----------------------------------------
    // frame sequencer
    // ----------------------------------------

    always_ff @(posedge clk or posedge rst)
        if (rst)
        begin
            state      <= rx_idle;
            cnt        <= '0;
            bit_idx    <= '0;
            byte_valid <= 1'b0;
        end
        else
        begin
            byte_valid <= 1'b0;
            cnt        <= cnt + 1'b1;

            case (state)
            rx_idle:
            begin
                cnt <= '0;
                // falling edge starts a frame
                if (rx_prev && !rx_sync[1])
                    state <= rx_start;
            end
            rx_start:
                // half a bit in, start bit must still be low
                if (cnt == w_cnt'(clocks_per_bit / 2 - 1))
                begin
                    cnt     <= '0;
                    bit_idx <= '0;
                    state   <= rx_sync[1] ? rx_idle : rx_data;
                end
            rx_data:
                if (cnt == w_cnt'(clocks_per_bit - 1))
                begin
                    cnt     <= '0;
                    bit_idx <= bit_idx + 1'b1;
                    if (bit_idx == 3'd7)
                        state <= rx_stop;
                end
            rx_stop:
                if (cnt == w_cnt'(clocks_per_bit - 1))
                begin
                    // low stop bit means framing error, byte dropped
                    byte_valid <= rx_sync[1];
                    state      <= rx_idle;
                end
            endcase
        end

    // data bits arrive lsb first
    always_ff @(posedge clk)
        if (state == rx_data && cnt == w_cnt'(clocks_per_bit - 1))
            shift <= {rx_sync[1], shift[7:1]};

    assign byte_data = shift;

endmodule

//--- common/hex_load_pkg.sv
package hex_load_pkg;

    // ----------------------------------------
    // widths with a meaning
    // ----------------------------------------

    // one serial character
    typedef logic [7:0]  byte_t;

    // value of a single hex digit
    typedef logic [3:0]  nibble_t;

    typedef logic [31:0] word_t;

    // byte address, advances by 4 per word
    typedef logic [31:0] addr_t;

    // ----------------------------------------
    // parser output and state
    // ----------------------------------------

    typedef struct packed
    {
        addr_t address;
        word_t data;
    } parsed_word_t;

    // ps_idle    no token in progress
    // ps_address token after '@'
    // ps_data    plain data token
    // ps_error   waiting for line feed
    typedef enum logic [1:0]
    {
        ps_idle,
        ps_address,
        ps_data,
        ps_error
    } parser_state_t;

endpackage

//--- common/hex_load_defs.svh
`ifndef HEX_LOAD_DEFS_SVH
`define HEX_LOAD_DEFS_SVH

// ----------------------------------------
// board clock and serial line
// ----------------------------------------

`define HL_CLK_MHZ          50

// 50 MHz / 115200 baud
`define HL_CLOCKS_PER_BIT   434

// ----------------------------------------
// parser and display timing
// ----------------------------------------

// one second of clock cycles
`define HL_TIMEOUT_CYCLES   (`HL_CLK_MHZ * 1000 * 1000)

// about 1 kHz per digit
`define HL_REFRESH_CYCLES   50000
`define HL_W_DIGIT          8

`endif
